// File: source/backend_pkg.sv
package backend_pkg;

    // Address and data width
    localparam int XLEN = 32;

    // Fetch target queue
    localparam int FTQ_SIZE = 8;
    localparam int FTQ_ID_W = $clog2(FTQ_SIZE);  // Id width, 3 for 8 entries

    // Lane counts around the backend
    localparam int MEM_LANES = 2;  // Memory stage lanes sharing the data cache
    localparam int EXE_LANES = 2;  // Execute lanes with a branch unit

    // Architectural register number
    localparam int REG_ADDR_W = 5;

    // Data cache request fields
    localparam int BYTE_SEL_W = 4;  // One strobe bit per byte of a word
    localparam int ACC_TYPE_W = 3;  // Read and write type code

    // Commit trace write enable, only bit 0 is meaningful
    localparam int DBG_WEN_W = 4;

    // Fixed instruction length, refetch resumes after the idle instruction
    localparam int INSTR_BYTES = 4;

endpackage

// File: source/redirect_select.sv
`timescale 1ns/1ps

module redirect_select (
    // Control flush sources
    input  logic                                              excp_flush_i,
    input  logic                                              excp_tlbrefill_i,
    input  logic                                              ertn_flush_i,
    input  logic                                              idle_flush_i,
    input  logic                                              refetch_flush_i,
    // Redirect targets from the CSR side
    input  logic [backend_pkg::XLEN-1:0]                      eentry_i,
    input  logic [backend_pkg::XLEN-1:0]                      tlbrentry_i,
    input  logic [backend_pkg::XLEN-1:0]                      era_i,
    input  logic [backend_pkg::XLEN-1:0]                      idle_pc_i,
    input  logic [backend_pkg::FTQ_ID_W-1:0]                  commit_ftq_id_i,
    // Execute lane branches
    input  logic [backend_pkg::EXE_LANES-1:0]                 branch_flag_i,
    input  logic [backend_pkg::EXE_LANES-1:0][backend_pkg::XLEN-1:0]     branch_target_i,
    input  logic [backend_pkg::EXE_LANES-1:0][backend_pkg::FTQ_ID_W-1:0] branch_ftq_id_i,
    input  logic                                              ex_stall_i,
    // Frontend redirect
    output logic                                              flush_o,
    output logic [backend_pkg::XLEN-1:0]                      next_pc_o,
    output logic [backend_pkg::FTQ_ID_W-1:0]                  flush_ftq_id_o
);

    logic                                 ctrl_flush;
    logic [backend_pkg::EXE_LANES-1:0]    branch_take;
    logic [backend_pkg::XLEN-1:0]         branch_pc;
    logic [backend_pkg::FTQ_ID_W-1:0]     branch_ftq_id;

    // Anything that is not a branch redirects from the commit point
    assign ctrl_flush = excp_flush_i | ertn_flush_i | idle_flush_i | refetch_flush_i;

    // A stalled execute stage may hold a branch resolved on stale operands
    assign branch_take = branch_flag_i & {backend_pkg::EXE_LANES{~ex_stall_i}};

    assign flush_o = ctrl_flush | (|branch_take);

    // Lowest lane is the oldest, so scan downward and let it overwrite
    always_comb begin
        branch_pc     = '0;
        branch_ftq_id = '0;
        for (int i = backend_pkg::EXE_LANES - 1; i >= 0; i--) begin
            if (branch_take[i]) begin
                branch_pc     = branch_target_i[i];
                branch_ftq_id = branch_ftq_id_i[i];
            end
        end
    end

    always_comb begin
        if (excp_flush_i && !excp_tlbrefill_i) begin
            next_pc_o = eentry_i;
        end else if (excp_flush_i) begin
            next_pc_o = tlbrentry_i;            // TLB refill has its own entry
        end else if (ertn_flush_i) begin
            next_pc_o = era_i;
        end else if (idle_flush_i) begin
            next_pc_o = idle_pc_i;
        end else if (refetch_flush_i) begin
            next_pc_o = idle_pc_i + backend_pkg::XLEN'(backend_pkg::INSTR_BYTES);
        end else begin
            next_pc_o = branch_pc;              // Zero when no lane branches
        end
    end

    assign flush_ftq_id_o = ctrl_flush ? commit_ftq_id_i : branch_ftq_id;

endmodule

// File: source/dcache_port_merge.sv
`timescale 1ns/1ps

module dcache_port_merge (
    input  logic [backend_pkg::MEM_LANES-1:0]                             mem_ce_i,
    input  logic [backend_pkg::MEM_LANES-1:0]                             mem_we_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::BYTE_SEL_W-1:0] mem_sel_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::ACC_TYPE_W-1:0] mem_rd_type_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::ACC_TYPE_W-1:0] mem_wr_type_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::XLEN-1:0]       mem_addr_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::XLEN-1:0]       mem_wdata_i,
    // Single request toward the data cache
    output logic                                                          dc_valid_o,
    output logic                                                          dc_write_o,
    output logic [backend_pkg::BYTE_SEL_W-1:0]                            dc_wstrb_o,
    output logic [backend_pkg::ACC_TYPE_W-1:0]                            dc_rd_type_o,
    output logic [backend_pkg::ACC_TYPE_W-1:0]                            dc_wr_type_o,
    output logic [backend_pkg::XLEN-1:0]                                  dc_addr_o,
    output logic [backend_pkg::XLEN-1:0]                                  dc_wdata_o
);

    assign dc_valid_o = |mem_ce_i;
    assign dc_write_o = |mem_we_i;

    // Write payload follows the lowest writing lane
    always_comb begin
        dc_wstrb_o = '0;
        dc_wdata_o = '0;
        for (int i = backend_pkg::MEM_LANES - 1; i >= 0; i--) begin
            if (mem_we_i[i]) begin
                dc_wstrb_o = mem_sel_i[i];
                dc_wdata_o = mem_wdata_i[i];
            end
        end
    end

    // Access types follow the lowest active lane
    always_comb begin
        dc_rd_type_o = '0;
        dc_wr_type_o = '0;
        for (int i = backend_pkg::MEM_LANES - 1; i >= 0; i--) begin
            if (mem_ce_i[i]) begin
                dc_rd_type_o = mem_rd_type_i[i];
                dc_wr_type_o = mem_wr_type_i[i];
            end
        end
    end

    // Idle lanes drive a zero address, so an OR is enough
    always_comb begin
        dc_addr_o = '0;
        for (int i = 0; i < backend_pkg::MEM_LANES; i++) begin
            dc_addr_o = dc_addr_o | mem_addr_i[i];
        end
    end

endmodule

// File: source/commit_trace.sv
`timescale 1ns/1ps

module commit_trace #(
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n_i,
    // Register file write-back per commit lane
    input  logic [COMMIT_WIDTH-1:0]                                wb_we_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]         wb_pc_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::REG_ADDR_W-1:0]   wb_waddr_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]         wb_wdata_i,
    // Debug trace, one cycle behind write-back
    output logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]         dbg_pc_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::DBG_WEN_W-1:0]    dbg_wen_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::REG_ADDR_W-1:0]   dbg_wnum_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]         dbg_wdata_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dbg_pc_o    <= '0;
            dbg_wen_o   <= '0;
            dbg_wnum_o  <= '0;
            dbg_wdata_o <= '0;
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                dbg_pc_o[i]    <= wb_pc_i[i];
                // Trace format has a byte-wide enable, we sits in bit 0
                dbg_wen_o[i]   <= {{(backend_pkg::DBG_WEN_W - 1){1'b0}}, wb_we_i[i]};
                dbg_wnum_o[i]  <= wb_waddr_i[i];
                dbg_wdata_o[i] <= wb_wdata_i[i];
            end
        end
    end

endmodule

// File: source/backend_link_top.sv
`timescale 1ns/1ps

module backend_link_top #(
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                                                          clk,
    input  logic                                                          rst_n_i,
    // Redirect sources
    input  logic                                                          excp_flush_i,
    input  logic                                                          excp_tlbrefill_i,
    input  logic                                                          ertn_flush_i,
    input  logic                                                          idle_flush_i,
    input  logic                                                          refetch_flush_i,
    input  logic [backend_pkg::XLEN-1:0]                                  eentry_i,
    input  logic [backend_pkg::XLEN-1:0]                                  tlbrentry_i,
    input  logic [backend_pkg::XLEN-1:0]                                  era_i,
    input  logic [backend_pkg::XLEN-1:0]                                  idle_pc_i,
    input  logic [backend_pkg::FTQ_ID_W-1:0]                              commit_ftq_id_i,
    input  logic [backend_pkg::EXE_LANES-1:0]                             branch_flag_i,
    input  logic [backend_pkg::EXE_LANES-1:0][backend_pkg::XLEN-1:0]      branch_target_i,
    input  logic [backend_pkg::EXE_LANES-1:0][backend_pkg::FTQ_ID_W-1:0]  branch_ftq_id_i,
    input  logic                                                          ex_stall_i,
    output logic                                                          flush_o,
    output logic [backend_pkg::XLEN-1:0]                                  next_pc_o,
    output logic [backend_pkg::FTQ_ID_W-1:0]                              flush_ftq_id_o,
    // Memory lanes toward the data cache
    input  logic [backend_pkg::MEM_LANES-1:0]                             mem_ce_i,
    input  logic [backend_pkg::MEM_LANES-1:0]                             mem_we_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::BYTE_SEL_W-1:0] mem_sel_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::ACC_TYPE_W-1:0] mem_rd_type_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::ACC_TYPE_W-1:0] mem_wr_type_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::XLEN-1:0]       mem_addr_i,
    input  logic [backend_pkg::MEM_LANES-1:0][backend_pkg::XLEN-1:0]       mem_wdata_i,
    output logic                                                          dc_valid_o,
    output logic                                                          dc_write_o,
    output logic [backend_pkg::BYTE_SEL_W-1:0]                            dc_wstrb_o,
    output logic [backend_pkg::ACC_TYPE_W-1:0]                            dc_rd_type_o,
    output logic [backend_pkg::ACC_TYPE_W-1:0]                            dc_wr_type_o,
    output logic [backend_pkg::XLEN-1:0]                                  dc_addr_o,
    output logic [backend_pkg::XLEN-1:0]                                  dc_wdata_o,
    // Commit write-back and its trace
    input  logic [COMMIT_WIDTH-1:0]                                       wb_we_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]                wb_pc_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::REG_ADDR_W-1:0]          wb_waddr_i,
    input  logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]                wb_wdata_i,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]                dbg_pc_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::DBG_WEN_W-1:0]           dbg_wen_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::REG_ADDR_W-1:0]          dbg_wnum_o,
    output logic [COMMIT_WIDTH-1:0][backend_pkg::XLEN-1:0]                dbg_wdata_o
);

    redirect_select u_redirect_select (
        .excp_flush_i     (excp_flush_i),
        .excp_tlbrefill_i (excp_tlbrefill_i),
        .ertn_flush_i     (ertn_flush_i),
        .idle_flush_i     (idle_flush_i),
        .refetch_flush_i  (refetch_flush_i),
        .eentry_i         (eentry_i),
        .tlbrentry_i      (tlbrentry_i),
        .era_i            (era_i),
        .idle_pc_i        (idle_pc_i),
        .commit_ftq_id_i  (commit_ftq_id_i),
        .branch_flag_i    (branch_flag_i),
        .branch_target_i  (branch_target_i),
        .branch_ftq_id_i  (branch_ftq_id_i),
        .ex_stall_i       (ex_stall_i),
        .flush_o          (flush_o),
        .next_pc_o        (next_pc_o),
        .flush_ftq_id_o   (flush_ftq_id_o)
    );

    dcache_port_merge u_dcache_port_merge (
        .mem_ce_i      (mem_ce_i),
        .mem_we_i      (mem_we_i),
        .mem_sel_i     (mem_sel_i),
        .mem_rd_type_i (mem_rd_type_i),
        .mem_wr_type_i (mem_wr_type_i),
        .mem_addr_i    (mem_addr_i),
        .mem_wdata_i   (mem_wdata_i),
        .dc_valid_o    (dc_valid_o),
        .dc_write_o    (dc_write_o),
        .dc_wstrb_o    (dc_wstrb_o),
        .dc_rd_type_o  (dc_rd_type_o),
        .dc_wr_type_o  (dc_wr_type_o),
        .dc_addr_o     (dc_addr_o),
        .dc_wdata_o    (dc_wdata_o)
    );

    commit_trace #(
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_commit_trace (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_we_i      (wb_we_i),
        .wb_pc_i      (wb_pc_i),
        .wb_waddr_i   (wb_waddr_i),
        .wb_wdata_i   (wb_wdata_i),
        .dbg_pc_o     (dbg_pc_o),
        .dbg_wen_o    (dbg_wen_o),
        .dbg_wnum_o   (dbg_wnum_o),
        .dbg_wdata_o  (dbg_wdata_o)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

endmodule

// File: dv/backend_link_tb.sv
`timescale 1ns/1ps

module backend_link_tb;

    localparam int    COMMIT_WIDTH = 2;
    localparam int    EDGE_LIMIT   = 200;  // Polls of 100 ps, two clock periods
    localparam string VEC_FILE     = "dv/backend_link_input.txt";

    logic        clk;
    logic        rst_n_i;
    logic        excp_flush_i, excp_tlbrefill_i, ertn_flush_i, idle_flush_i, refetch_flush_i;
    logic [31:0] eentry_i, tlbrentry_i, era_i, idle_pc_i;
    logic [2:0]  commit_ftq_id_i;
    logic [1:0]  branch_flag_i;
    logic [1:0][31:0] branch_target_i;
    logic [1:0][2:0]  branch_ftq_id_i;
    logic        ex_stall_i;
    logic        flush_o;
    logic [31:0] next_pc_o;
    logic [2:0]  flush_ftq_id_o;
    logic [1:0]  mem_ce_i, mem_we_i;
    logic [1:0][3:0]  mem_sel_i;
    logic [1:0][2:0]  mem_rd_type_i, mem_wr_type_i;
    logic [1:0][31:0] mem_addr_i, mem_wdata_i;
    logic        dc_valid_o, dc_write_o;
    logic [3:0]  dc_wstrb_o;
    logic [2:0]  dc_rd_type_o, dc_wr_type_o;
    logic [31:0] dc_addr_o, dc_wdata_o;
    logic [COMMIT_WIDTH-1:0]       wb_we_i;
    logic [COMMIT_WIDTH-1:0][31:0] wb_pc_i, wb_wdata_i, dbg_pc_o, dbg_wdata_o;
    logic [COMMIT_WIDTH-1:0][4:0]  wb_waddr_i, dbg_wnum_o;
    logic [COMMIT_WIDTH-1:0][3:0]  dbg_wen_o;

    // One vector as read from the file
    logic [4:0]  s_flags;  // excp, tlbrefill, ertn, idle, refetch
    logic [31:0] s_eentry, s_tlbrentry, s_era, s_idle_pc;
    logic [2:0]  s_cid;
    logic [1:0]  s_bf;
    logic [31:0] s_tgt [2];
    logic [2:0]  s_bid [2];
    logic        s_stall;
    logic        e_flush;
    logic [31:0] e_pc;
    logic [2:0]  e_id;
    logic [1:0]  s_ce, s_we;
    logic [3:0]  s_sel [2];
    logic [2:0]  s_rdt [2];
    logic [2:0]  s_wrt [2];
    logic [31:0] s_addr [2];
    logic [31:0] s_wd [2];
    logic        e_valid, e_write;
    logic [3:0]  e_wstrb;
    logic [2:0]  e_rdt, e_wrt;
    logic [31:0] e_addr, e_wdata;
    logic [1:0]  s_wbwe;
    logic [31:0] s_wbpc [2];
    logic [4:0]  s_wa [2];
    logic [31:0] s_wbd [2];

    // Write-back sampled at the last rising edge
    logic [1:0]  e_wbwe;
    logic [31:0] e_wbpc [2];
    logic [4:0]  e_wa [2];
    logic [31:0] e_wbd [2];

    tb_clock_gen #(.PERIOD_NS(10.0)) u_clock_gen (.clk_o(clk));

    backend_link_top #(
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) backend_link_top_i (.*);

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Poll for a transition of clk to the given level
    task automatic wait_edge(input logic to_level);
        int   polls;
        logic prev;
        polls = 0;
        prev  = clk;
        while (!(prev === ~to_level && clk === to_level)) begin
            if (polls >= EDGE_LIMIT) begin
                $display("Timed out at %0t while waiting for a clock edge", $time);
                $display("TB FAILED");
                $fatal(1, "clock edge timeout");
            end
            prev = clk;
            #0.1;
            polls++;
        end
    endtask

    task automatic report_bad_vector(input string why);
        $display("The vector file %s is malformed: %s", VEC_FILE, why);
        $display("TB FAILED");
        $fatal(1, "bad vector file");
    endtask

    task automatic drive_vector();
        {excp_flush_i, excp_tlbrefill_i, ertn_flush_i, idle_flush_i, refetch_flush_i} = s_flags;
        eentry_i        = s_eentry;
        tlbrentry_i     = s_tlbrentry;
        era_i           = s_era;
        idle_pc_i       = s_idle_pc;
        commit_ftq_id_i = s_cid;
        branch_flag_i   = s_bf;
        ex_stall_i      = s_stall;
        mem_ce_i        = s_ce;
        mem_we_i        = s_we;
        wb_we_i         = s_wbwe;
        for (int i = 0; i < 2; i++) begin
            branch_target_i[i] = s_tgt[i];
            branch_ftq_id_i[i] = s_bid[i];
            mem_sel_i[i]       = s_sel[i];
            mem_rd_type_i[i]   = s_rdt[i];
            mem_wr_type_i[i]   = s_wrt[i];
            mem_addr_i[i]      = s_addr[i];
            // Write data of a lane that does not write is don't-care
            mem_wdata_i[i]     = s_we[i] ? s_wd[i] : $urandom;
            wb_pc_i[i]         = s_wbpc[i];
            wb_waddr_i[i]      = s_wa[i];
            wb_wdata_i[i]      = s_wbd[i];
        end
    endtask

    task automatic check_comb();
        check_value("flush_o", 32'(flush_o), 32'(e_flush));
        check_value("next_pc_o", next_pc_o, e_pc);
        check_value("flush_ftq_id_o", 32'(flush_ftq_id_o), 32'(e_id));
        check_value("dc_valid_o", 32'(dc_valid_o), 32'(e_valid));
        check_value("dc_write_o", 32'(dc_write_o), 32'(e_write));
        check_value("dc_wstrb_o", 32'(dc_wstrb_o), 32'(e_wstrb));
        check_value("dc_rd_type_o", 32'(dc_rd_type_o), 32'(e_rdt));
        check_value("dc_wr_type_o", 32'(dc_wr_type_o), 32'(e_wrt));
        check_value("dc_addr_o", dc_addr_o, e_addr);
        check_value("dc_wdata_o", dc_wdata_o, e_wdata);
    endtask

    // Trace shows the sampled write-back, enable widened into bit 0
    task automatic check_trace();
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            check_value($sformatf("dbg_pc_o[%0d]", i), dbg_pc_o[i], e_wbpc[i]);
            check_value($sformatf("dbg_wen_o[%0d]", i), 32'(dbg_wen_o[i]),
                        {31'b0, e_wbwe[i]});
            check_value($sformatf("dbg_wnum_o[%0d]", i), 32'(dbg_wnum_o[i]),
                        32'(e_wa[i]));
            check_value($sformatf("dbg_wdata_o[%0d]", i), dbg_wdata_o[i], e_wbd[i]);
        end
    endtask

    initial begin
        int    fd;
        int    got;
        int    part;
        int    vec_count;
        string line;
        void'($urandom(32'h7830));
        $timeformat(-9, 1, " ns", 0);
        rst_n_i = 1'b0;
        {excp_flush_i, excp_tlbrefill_i, ertn_flush_i, idle_flush_i, refetch_flush_i} = '0;
        {eentry_i, tlbrentry_i, era_i, idle_pc_i, commit_ftq_id_i} = '0;
        {branch_flag_i, branch_target_i, branch_ftq_id_i, ex_stall_i} = '0;
        {mem_ce_i, mem_we_i, mem_sel_i, mem_rd_type_i, mem_wr_type_i} = '0;
        {mem_addr_i, mem_wdata_i} = '0;
        // Busy write-back during reset, only the reset keeps the trace clear
        {wb_we_i, wb_pc_i, wb_waddr_i, wb_wdata_i} = '1;
        e_wbwe = '0;
        e_wbpc = '{default: '0};
        e_wa   = '{default: '0};
        e_wbd  = '{default: '0};

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            $display("TB FAILED");
            $fatal(1, "missing vector file");
        end

        repeat (8) wait_edge(1'b1);
        wait_edge(1'b0);
        rst_n_i = 1'b1;
        {wb_we_i, wb_pc_i, wb_waddr_i, wb_wdata_i} = '0;
        #1;
        check_trace();  // Nothing sampled yet

        part      = 0;
        vec_count = 0;
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
            if (part == 0) begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              s_flags, s_eentry, s_tlbrentry, s_era, s_idle_pc, s_cid, s_bf,
                              s_tgt[0], s_tgt[1], s_bid[0], s_bid[1], s_stall,
                              e_flush, e_pc, e_id);
                if (got != 15) report_bad_vector("short redirect line");
            end else if (part == 1) begin
                got = $sscanf(line,
                              "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              s_ce, s_we, s_sel[0], s_sel[1], s_rdt[0], s_rdt[1],
                              s_wrt[0], s_wrt[1], s_addr[0], s_addr[1], s_wd[0], s_wd[1],
                              e_valid, e_write, e_wstrb, e_rdt, e_wrt, e_addr, e_wdata);
                if (got != 19) report_bad_vector("short cache merge line");
            end else begin
                got = $sscanf(line, "%h %h %h %h %h %h %h", s_wbwe, s_wbpc[0], s_wbpc[1],
                              s_wa[0], s_wa[1], s_wbd[0], s_wbd[1]);
                if (got != 7) report_bad_vector("short commit trace line");
                wait_edge(1'b0);
                drive_vector();
                #4;
                check_comb();   // Just before the sampling edge
                check_trace();  // Still the previous write-back
                wait_edge(1'b1);
                #1;
                e_wbwe = s_wbwe;
                e_wbpc = s_wbpc;
                e_wa   = s_wa;
                e_wbd  = s_wbd;
                check_trace();
                vec_count++;
            end
            part = (part + 1) % 3;
        end
        $fclose(fd);
        if (part != 0 || vec_count == 0) report_bad_vector("incomplete or empty vector set");

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: dv/backend_link_input.txt
# Three lines per vector, all hex
# redirect: flags(excp,tlb,ertn,idle,refetch) eentry tlbrentry era idle_pc cid bflag tgt0 tgt1 id0 id1 stall | flush pc id
# merge: ce we sel0 sel1 rdt0 rdt1 wrt0 wrt1 addr0 addr1 wd0 wd1 | valid write wstrb rdt wrt addr wdata
# trace: we pc0 pc1 waddr0 waddr1 wdata0 wdata1
1f 1c000000 1c001000 1c002000 1c003000 5 3 1c004000 1c005000 1 2 0 1 1c001000 5
2 0 0 0 0 2 0 0 00000000 00008040 00000000 00000000 1 0 0 2 0 00008040 00000000
3 1c000100 1c000104 01 1f deadbeef 12345678
17 1c000000 1c001000 1c002000 1c003000 3 1 1c004000 1c005000 1 2 0 1 1c000000 3
3 3 f 3 0 0 2 1 00001000 00000004 a5a5a5a5 5a5a5a5a 1 1 f 0 2 00001004 a5a5a5a5
1 1c000108 1c00010c 02 03 00000011 00000022
07 1c000000 1c001000 1c002000 1c003000 7 0 1c004000 1c005000 1 2 0 1 1c002000 7
0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 00000000
2 1c000110 1c000114 04 05 00000033 00000044
03 1c000000 1c001000 1c002000 1c003000 6 2 1c004000 1c005000 1 2 0 1 1c003000 6
2 2 0 c 0 0 0 3 00000000 00002008 00000000 cafef00d 1 1 c 0 3 00002008 cafef00d
0 1c000118 1c00011c 06 07 00000055 00000066
01 1c000000 1c001000 1c002000 1c003000 4 0 1c004000 1c005000 1 2 0 1 1c003004 4
1 0 0 0 4 0 0 0 00000400 00000000 00000000 00000000 1 0 0 4 0 00000400 00000000
3 1c000120 1c000124 08 09 00000077 00000088
00 1c000000 1c001000 1c002000 1c003000 5 3 1c004000 1c005000 1 2 0 1 1c004000 1
3 1 3 0 0 1 1 0 00000010 00000000 0000beef 00000000 1 1 3 0 1 00000010 0000beef
3 1c000128 1c00012c 0a 0b 00000099 000000aa
00 1c000000 1c001000 1c002000 1c003000 5 2 1c004000 1c005000 1 2 0 1 1c005000 2
0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 00000000
1 1c000130 1c000134 0c 0d 000000bb 000000cc
00 1c000000 1c001000 1c002000 1c003000 5 3 1c004000 1c005000 1 2 1 0 00000000 0
0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 00000000
2 1c000138 1c00013c 0e 0f 000000dd 000000ee

// File: all.f
source/backend_pkg.sv
source/redirect_select.sv
source/dcache_port_merge.sv
source/commit_trace.sv
source/backend_link_top.sv
dv/tb_clock_gen.sv
dv/backend_link_tb.sv

// File: Makefile
# Verilator build and run for the backend link testbench

TOP       ?= backend_link_tb
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@if grep -q "^TB PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
